/* hw/lobby_pkg.sv */
`default_nettype none

package lobby_pkg;

	//////////////////////////////
	// Game states
	//////////////////////////////

	typedef enum logic [1:0]
	{
		ST_IDLE   = 2'd0,
		ST_INVITE = 2'd1,
		ST_PLAY   = 2'd2,
		ST_RESULT = 2'd3
	} game_state_t;

	//////////////////////////////
	// Display geometry
	//////////////////////////////

	localparam int NUM_COLS = 16;
	localparam int CHAR_W   = 8;
	localparam int COL_W    = 4;
	localparam int ROW_W    = 128; // NUM_COLS * CHAR_W

	//////////////////////////////
	// Screen timing, in sec_tick units
	//////////////////////////////

	localparam int INVITE_SECONDS = 15;
	localparam int ROUND_SECONDS  = 10;
	localparam int RESULT_SECONDS = 3;

	localparam int TIMER_W = 4; // Wide enough for every timer above
	localparam int BCD_W   = 4; // One decimal digit

	//////////////////////////////
	// Character codes and fixed texts
	//////////////////////////////

	localparam logic [CHAR_W-1:0] CH_BLANK = 8'h20;
	localparam logic [CHAR_W-1:0] CH_ZERO  = 8'h30; // Digits follow in order

	// Column 0 lands in the top byte
	localparam logic [ROW_W-1:0] IDLE_TEXT = "PRESS INVITE    ";

	localparam logic [ROW_W/2-1:0] INVITE_WORD = "INVITE? ";

	// Pieces of the play and result rows
	localparam logic [5*CHAR_W-1:0]  TIME_WORD  = "TIME ";
	localparam logic [7*CHAR_W-1:0]  SCORE_WORD = " SCORE ";
	localparam logic [12*CHAR_W-1:0] FINAL_WORD = "FINAL SCORE ";

	//////////////////////////////
	// Digit formatting
	//////////////////////////////

	function automatic logic [CHAR_W-1:0] digit_char(input logic [BCD_W-1:0] digit);
		return CH_ZERO + {{(CHAR_W-BCD_W){1'b0}}, digit};
	endfunction

	// Binary 0..15 to two decimal characters, leading zero kept
	function automatic logic [2*CHAR_W-1:0] two_digits(input logic [TIMER_W-1:0] value);
		logic               tens;
		logic [TIMER_W-1:0] ones;
		tens = (value >= TIMER_W'(10));
		ones = tens ? value - TIMER_W'(10) : value;
		return {digit_char({{(BCD_W-1){1'b0}}, tens}), digit_char(ones)};
	endfunction

endpackage

`default_nettype wire

/* hw/game_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module game_ctrl
(
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               sec_tick,
	input  wire logic               btn_invite,
	input  wire logic               btn_accept,
	input  wire logic               btn_reject,
	input  wire logic               invite_timeout,
	input  wire logic               round_over,
	output lobby_pkg::game_state_t  game_state
);

	import lobby_pkg::*;

	game_state_t        state_d;
	logic [TIMER_W-1:0] hold_cnt; // Result screen time left
	logic               hold_done;

	//////////////////////////////
	// Result hold timer
	//////////////////////////////

	// Reloads outside RESULT, so it is full on entry
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			hold_cnt <= TIMER_W'(RESULT_SECONDS);
		else if (game_state != ST_RESULT)
			hold_cnt <= TIMER_W'(RESULT_SECONDS);
		else if (sec_tick && (hold_cnt != '0))
			hold_cnt <= hold_cnt - 1'b1;
	end

	assign hold_done = (game_state == ST_RESULT) && (hold_cnt == '0);

	//////////////////////////////
	// Next state
	//////////////////////////////

	always_comb
	begin
		state_d = game_state; // Stay by default
		case (game_state)
			ST_IDLE:
			begin
				if (btn_invite)
					state_d = ST_INVITE;
			end
			ST_INVITE:
			begin
				// Accept has priority
				if (btn_accept)
					state_d = ST_PLAY;
				else if (btn_reject || invite_timeout)
					state_d = ST_IDLE;
			end
			ST_PLAY:
			begin
				if (round_over)
					state_d = ST_RESULT;
			end
			ST_RESULT:
			begin
				if (hold_done)
					state_d = ST_IDLE;
			end
			default:
				state_d = ST_IDLE;
		endcase
	end

	//////////////////////////////
	// State register
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			game_state <= ST_IDLE;
		else
			game_state <= state_d;
	end

endmodule

`default_nettype wire

/* hw/invite_screen.sv */
`timescale 1ns/10ps
`default_nettype none

module invite_screen
(
	input  wire logic                         clk,
	input  wire logic                         rst_n,
	input  wire logic                         sec_tick,
	input  wire lobby_pkg::game_state_t       game_state,
	output logic                              invite_timeout,
	output logic [lobby_pkg::ROW_W-1:0]       invite_row
);

	import lobby_pkg::*;

	logic [TIMER_W-1:0]  cnt;         // Seconds left to answer
	logic [2*CHAR_W-1:0] count_chars;

	//////////////////////////////
	// Countdown
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cnt <= TIMER_W'(INVITE_SECONDS);
		else if (game_state != ST_INVITE)
			cnt <= TIMER_W'(INVITE_SECONDS); // Ready for the next invite
		else if (sec_tick && (cnt != '0))
			cnt <= cnt - 1'b1;
	end

	// Counter sits at 0 for one cycle in IDLE after leaving, hence the state term
	assign invite_timeout = (cnt == '0) && (game_state == ST_INVITE);

	//////////////////////////////
	// Screen text
	//////////////////////////////

	always_comb
	begin
		if (cnt == '0)
			count_chars = {CH_BLANK, CH_BLANK}; // Field goes blank at timeout
		else
			count_chars = two_digits(cnt);
	end

	// " nn INVITE?     "
	assign invite_row = {
		CH_BLANK,
		count_chars,
		CH_BLANK,
		INVITE_WORD,
		{4{CH_BLANK}}
	};

endmodule

`default_nettype wire

/* hw/play_screen.sv */
`timescale 1ns/10ps
`default_nettype none

module play_screen
(
	input  wire logic                         clk,
	input  wire logic                         rst_n,
	input  wire logic                         sec_tick,
	input  wire logic                         btn_hit,
	input  wire lobby_pkg::game_state_t       game_state,
	output logic                              round_over,
	output logic [lobby_pkg::ROW_W-1:0]       play_row
);

	import lobby_pkg::*;

	logic [TIMER_W-1:0] time_left;
	logic [BCD_W-1:0]   score_tens;
	logic [BCD_W-1:0]   score_ones;
	logic               score_max;

	assign score_max = (score_tens == BCD_W'(9)) && (score_ones == BCD_W'(9));

	//////////////////////////////
	// Round timer
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			time_left <= TIMER_W'(ROUND_SECONDS);
		else if (game_state == ST_IDLE)
			time_left <= TIMER_W'(ROUND_SECONDS);
		else if ((game_state == ST_PLAY) && sec_tick && (time_left != '0))
			time_left <= time_left - 1'b1;
	end

	// Stays high through RESULT, the timer only reloads in IDLE
	assign round_over = (time_left == '0) &&
		((game_state == ST_PLAY) || (game_state == ST_RESULT));

	//////////////////////////////
	// Hit counter, two BCD digits
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			score_tens <= '0;
			score_ones <= '0;
		end
		else if (game_state == ST_IDLE)
		begin
			score_tens <= '0;
			score_ones <= '0;
		end
		else if ((game_state == ST_PLAY) && btn_hit && !score_max)
		begin
			if (score_ones == BCD_W'(9))
			begin
				score_ones <= '0;
				score_tens <= score_tens + 1'b1; // Carry
			end
			else
				score_ones <= score_ones + 1'b1;
		end
	end

	//////////////////////////////
	// Screen text
	//////////////////////////////

	always_comb
	begin
		if (game_state == ST_RESULT)
			play_row = {FINAL_WORD, digit_char(score_tens), digit_char(score_ones),
				CH_BLANK, CH_BLANK};
		else
			play_row = {TIME_WORD, two_digits(time_left), SCORE_WORD,
				digit_char(score_tens), digit_char(score_ones)};
	end

endmodule

`default_nettype wire

/* hw/lcd_row_driver.sv */
`timescale 1ns/10ps
`default_nettype none

module lcd_row_driver
(
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire lobby_pkg::game_state_t        game_state,
	input  wire logic [lobby_pkg::ROW_W-1:0]   invite_row,
	input  wire logic [lobby_pkg::ROW_W-1:0]   play_row,
	output logic                               lcd_we,
	output logic [lobby_pkg::COL_W-1:0]        lcd_addr,
	output logic [lobby_pkg::CHAR_W-1:0]       lcd_char
);

	import lobby_pkg::*;

	logic [ROW_W-1:0] row_next;
	logic [ROW_W-1:0] row_q;   // Row being shown
	logic [COL_W-1:0] col_cnt;

	//////////////////////////////
	// Row select
	//////////////////////////////

	always_comb
	begin
		case (game_state)
			ST_INVITE:          row_next = invite_row;
			ST_PLAY, ST_RESULT: row_next = play_row;
			default:            row_next = IDLE_TEXT;
		endcase
	end

	always_ff @(posedge clk)
		row_q <= row_next; // One cycle behind the state

	//////////////////////////////
	// Column walk
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			lcd_we  <= 1'b0;
			col_cnt <= '0;
		end
		else
		begin
			lcd_we <= 1'b1; // Writes run continuously from here on
			if (lcd_we)
				col_cnt <= (col_cnt == COL_W'(NUM_COLS-1)) ? '0 : col_cnt + 1'b1;
		end
	end

	assign lcd_addr = col_cnt;
	assign lcd_char = row_q[ROW_W-1 - CHAR_W*col_cnt -: CHAR_W]; // Column 0 is the top byte

endmodule

`default_nettype wire

/* hw/lobby_top.sv */
`timescale 1ns/10ps
`default_nettype none

module lobby_top
(
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire logic                          sec_tick,
	input  wire logic                          btn_invite,
	input  wire logic                          btn_accept,
	input  wire logic                          btn_reject,
	input  wire logic                          btn_hit,
	output logic                               lcd_we,
	output logic [lobby_pkg::COL_W-1:0]        lcd_addr,
	output logic [lobby_pkg::CHAR_W-1:0]       lcd_char
);

	import lobby_pkg::*;

	game_state_t      game_state;
	logic             invite_timeout;
	logic             round_over;
	logic [ROW_W-1:0] invite_row;
	logic [ROW_W-1:0] play_row;

	//////////////////////////////
	// Control
	//////////////////////////////

	game_ctrl ctrl_i
	(
		.clk            (clk),
		.rst_n          (rst_n),
		.sec_tick       (sec_tick),
		.btn_invite     (btn_invite),
		.btn_accept     (btn_accept),
		.btn_reject     (btn_reject),
		.invite_timeout (invite_timeout),
		.round_over     (round_over),
		.game_state     (game_state)
	);

	//////////////////////////////
	// Screens and display
	//////////////////////////////

	invite_screen invite_i
	(
		.clk            (clk),
		.rst_n          (rst_n),
		.sec_tick       (sec_tick),
		.game_state     (game_state),
		.invite_timeout (invite_timeout),
		.invite_row     (invite_row)
	);

	play_screen play_i
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.sec_tick   (sec_tick),
		.btn_hit    (btn_hit),
		.game_state (game_state),
		.round_over (round_over),
		.play_row   (play_row)
	);

	lcd_row_driver driver_i
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.game_state (game_state),
		.invite_row (invite_row),
		.play_row   (play_row),
		.lcd_we     (lcd_we),
		.lcd_addr   (lcd_addr),
		.lcd_char   (lcd_char)
	);

endmodule

`default_nettype wire

/* testbench/lobby_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module lobby_checker
(
	input wire logic                        clk,
	input wire logic                        rst_n,
	input wire logic                        lcd_we,
	input wire logic [lobby_pkg::COL_W-1:0] lcd_addr,
	input wire logic [lobby_pkg::CHAR_W-1:0] lcd_char
);

	import lobby_pkg::*;

	logic [ROW_W-1:0] shadow; // What the display holds now
	int               pass_count = 0;
	int               fail_count = 0;

	//////////////////////////////
	// Display model
	//////////////////////////////

	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			shadow <= {NUM_COLS{CH_BLANK}};
		else if (lcd_we)
			shadow[ROW_W-1 - CHAR_W*lcd_addr -: CHAR_W] <= lcd_char;
	end

	// Column 0 goes to the top byte, short texts are padded with blanks
	function automatic logic [ROW_W-1:0] text_to_row(input string text);
		logic [ROW_W-1:0] row;
		row = {NUM_COLS{CH_BLANK}};
		for (int i = 0; (i < NUM_COLS) && (i < text.len()); i++)
			row[ROW_W-1 - CHAR_W*i -: CHAR_W] = text[i];
		return row;
	endfunction

	//////////////////////////////
	// Compare
	//////////////////////////////

	task automatic compare_row(input string name, input string expected);
		logic [ROW_W-1:0] want;
		want = text_to_row(expected);
		if (shadow === want)
		begin
			pass_count++;
			$display("[PASS] %s", name);
		end
		else
		begin
			fail_count++;
			$display("[FAIL] %s expected \"%s\" actual \"%s\"", name, expected,
				$sformatf("%s", shadow));
		end
	endtask

endmodule

`default_nettype wire

/* testbench/lobby_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module lobby_properties
(
	input wire logic                         clk,
	input wire logic                         rst_n,
	input wire logic                         lcd_we,
	input wire logic [lobby_pkg::COL_W-1:0]  lcd_addr,
	input wire lobby_pkg::game_state_t       game_state,
	input wire logic                         round_over
);

	import lobby_pkg::*;

	int assert_errors = 0;

	// Low on the first edge after release, high on every edge after that
	we_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
		lcd_we == $past(rst_n))
	else
	begin
		assert_errors++;
		$error("lcd_we was not high on every cycle after reset");
	end

	// Columns wrap from 15 back to 0
	addr_step: assert property (@(posedge clk) disable iff (!rst_n)
		lcd_we |=> (lcd_addr == COL_W'($past(lcd_addr) + 1'b1)))
	else
	begin
		assert_errors++;
		$error("lcd_addr did not advance by one after a write");
	end

	no_invite_to_result: assert property (@(posedge clk) disable iff (!rst_n)
		(game_state == ST_INVITE) |=> (game_state != ST_RESULT))
	else
	begin
		assert_errors++;
		$error("state went from INVITE straight to RESULT");
	end

	round_over_scope: assert property (@(posedge clk) disable iff (!rst_n)
		round_over |-> ((game_state == ST_PLAY) || (game_state == ST_RESULT)))
	else
	begin
		assert_errors++;
		$error("round_over was high outside PLAY and RESULT");
	end

endmodule

// Top level sees both the driver outputs and the controller signals
bind lobby_top lobby_properties props_i
(
	.clk        (clk),
	.rst_n      (rst_n),
	.lcd_we     (lcd_we),
	.lcd_addr   (lcd_addr),
	.game_state (game_state),
	.round_over (round_over)
);

`default_nettype wire

/* testbench/tb_lobby.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_lobby;

	import lobby_pkg::*;

	typedef enum int {ACT_INVITE, ACT_ACCEPT, ACT_REJECT, ACT_HIT, ACT_TICK} action_t;

	logic              clk;
	logic              rst_n;
	logic              sec_tick;
	logic              btn_invite;
	logic              btn_accept;
	logic              btn_reject;
	logic              btn_hit;
	logic              lcd_we;
	logic [COL_W-1:0]  lcd_addr;
	logic [CHAR_W-1:0] lcd_char;

	// Stimulus table, one entry per test
	string       row_name[$];
	action_t     row_act[$];
	int          row_count[$];
	string       row_text[$];
	logic [31:0] lfsr;
	int          watchdog_cycles = 0;

	lobby_top dut_i
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.sec_tick   (sec_tick),
		.btn_invite (btn_invite),
		.btn_accept (btn_accept),
		.btn_reject (btn_reject),
		.btn_hit    (btn_hit),
		.lcd_we     (lcd_we),
		.lcd_addr   (lcd_addr),
		.lcd_char   (lcd_char)
	);

	lobby_checker checker_i
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.lcd_we   (lcd_we),
		.lcd_addr (lcd_addr),
		.lcd_char (lcd_char)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h8020_0003;
		return state >> 1;
	endfunction

	function automatic void add_row(input string name, input action_t act, input int count,
		input string text);
		row_name.push_back(name);
		row_act.push_back(act);
		row_count.push_back(count);
		row_text.push_back(text);
	endfunction

	task automatic clear_inputs();
		sec_tick   = 1'b0;
		btn_invite = 1'b0;
		btn_accept = 1'b0;
		btn_reject = 1'b0;
		btn_hit    = 1'b0;
	endtask

	// Two fresh bits give a gap of 1 to 3 cycles
	task automatic next_gap(output int gap);
		int bits;
		bits = 0;
		for (int i = 0; i < 2; i++)
		begin
			lfsr = lfsr_step(lfsr);
			bits = (bits << 1) | int'(lfsr[0]);
		end
		gap = 1 + bits % 3;
	endtask

	task automatic pulse_input(input action_t act);
		@(posedge clk);
		#1;
		case (act)
			ACT_INVITE: btn_invite = 1'b1;
			ACT_ACCEPT: btn_accept = 1'b1;
			ACT_REJECT: btn_reject = 1'b1;
			ACT_HIT:    btn_hit    = 1'b1;
			default:    sec_tick   = 1'b1;
		endcase
		@(posedge clk);
		#1;
		clear_inputs(); // One-cycle pulse
	endtask

	task automatic apply_row(input int r);
		int gap;
		for (int n = 0; n < row_count[r]; n++)
		begin
			pulse_input(row_act[r]);
			if (row_act[r] == ACT_TICK)
				repeat (2) @(posedge clk); // Ticks 4 cycles apart
			else if (row_act[r] == ACT_HIT)
			begin
				next_gap(gap);
				repeat (gap - 1) @(posedge clk);
			end
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		int total;
		clear_inputs();
		rst_n = 1'b0;
		lfsr  = 32'hbf38ccae;

		add_row("idle_ignore_accept", ACT_ACCEPT, 1,   "PRESS INVITE    ");
		add_row("idle_ignore_reject", ACT_REJECT, 1,   "PRESS INVITE    ");
		add_row("invite_start",       ACT_INVITE, 1,   " 15 INVITE?     ");
		add_row("invite_count",       ACT_TICK,   5,   " 10 INVITE?     ");
		add_row("invite_timeout",     ACT_TICK,   10,  "PRESS INVITE    ");
		add_row("invite_again",       ACT_INVITE, 1,   " 15 INVITE?     ");
		add_row("invite_reject",      ACT_REJECT, 1,   "PRESS INVITE    ");
		add_row("invite_third",       ACT_INVITE, 1,   " 15 INVITE?     ");
		add_row("accept_play",        ACT_ACCEPT, 1,   "TIME 10 SCORE 00");
		add_row("hits_small",         ACT_HIT,    7,   "TIME 10 SCORE 07");
		add_row("play_ticks",         ACT_TICK,   3,   "TIME 07 SCORE 07");
		add_row("hits_capped",        ACT_HIT,    100, "TIME 07 SCORE 99");
		add_row("round_end",          ACT_TICK,   7,   "FINAL SCORE 99  ");
		add_row("result_end",         ACT_TICK,   3,   "PRESS INVITE    ");
		add_row("new_invite",         ACT_INVITE, 1,   " 15 INVITE?     ");
		add_row("new_game",           ACT_ACCEPT, 1,   "TIME 10 SCORE 00");

		total = 0;
		foreach (row_count[r])
			total += row_count[r];
		watchdog_cycles = total * 4 + row_count.size() * 40 + 200;

		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		for (int r = 0; r < row_name.size(); r++)
		begin
			apply_row(r);
			repeat (40) @(posedge clk); // More than two full refreshes
			#1;
			checker_i.compare_row(row_name[r], row_text[r]);
		end

		$display("Tests passed: %0d, failed: %0d, assertion errors: %0d",
			checker_i.pass_count, checker_i.fail_count, dut_i.props_i.assert_errors);
		if ((checker_i.fail_count == 0) && (dut_i.props_i.assert_errors == 0))
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Watchdog
	initial
	begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
hw/lobby_pkg.sv
hw/game_ctrl.sv
hw/invite_screen.sv
hw/play_screen.sv
hw/lcd_row_driver.sv
hw/lobby_top.sv
testbench/lobby_checker.sv
testbench/lobby_properties.sv
testbench/tb_lobby.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_lobby
FILELIST  = build.f
OBJ_DIR   = obj_dir
RUN_ARGS  = +verilator+error+limit+1000
PASS_MSG  = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
